//--- include/uart_consts.svh
// uart transmit constants
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// frame format

`define dataBits     8    // bits per frame, lsb first
`define sbTick       16   // ticks in the stop bit (16 = one stop bit)

////////////////////////////////////////////////////////////////////////////
// baud rate

// clocks per oversampling tick, one bit is 16 ticks
`define baudDivisor  4

////////////////////////////////////////////////////////////////////////////
// lanes and queues

`define txChannels   4    // serial lanes
`define chanSelLen   2    // lane index width
`define fifoDepth    8    // bytes per lane fifo
`define fifoAddrLen  3    // fifo pointer width
`define countLen     8    // frame counter width, wraps

`endif

//--- hdl/uartPkg.sv
// uart transmit types
`default_nettype none

`include "uart_consts.svh"

package uartPkg;

	// transmitter fsm
	typedef enum logic [1:0] {
		idle  = 2'b00,
		start = 2'b01,
		data  = 2'b10,
		stop  = 2'b11
	} txState_e;

	// host opcodes
	typedef enum logic {
		opSend  = 1'b0,   // queue a byte
		opCount = 1'b1    // read frame count
	} hostOp_e;

	typedef struct packed {
		hostOp_e                op;
		logic [`chanSelLen-1:0] chan;
		logic [`dataBits-1:0]   data;
	} hostCmd_t;

	typedef struct packed {
		logic                 accepted;   // byte went into a fifo
		logic [`countLen-1:0] data;       // count read back
	} hostRsp_t;

	typedef struct packed {
		logic                 busy;
		logic [`countLen-1:0] sentCount;
	} chanStatus_t;

endpackage

`default_nettype wire

//--- hdl/baudGen.sv
// oversampling tick generator
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module baudGen (
	input  logic clk,
	input  logic reset,
	output logic sTick     // one clock wide, shared by all lanes
);

	localparam int divLen = $clog2(`baudDivisor);
	localparam logic [divLen-1:0] divLast = divLen'(`baudDivisor - 1);

	logic [divLen-1:0] divCnt;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			sTick <= (divCnt == divLast);   // registered, no glitches
			if (divCnt == divLast)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
		end
	end

	// lanes count ticks, back to back ticks would skew every bit
	assert property (@(posedge clk) disable iff (reset) sTick |=> !sTick);

endmodule

`default_nettype wire

//--- hdl/txFifo.sv
// lane byte fifo
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module txFifo (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 push,
	input  logic [`dataBits-1:0] pushData,
	input  logic                 pop,
	output logic [`dataBits-1:0] popData,   // head byte, valid while !empty
	output logic                 full,
	output logic                 empty
);

	localparam int cntLen = `fifoAddrLen + 1;
	localparam logic [cntLen-1:0] maxCnt = cntLen'(`fifoDepth);

	logic [`dataBits-1:0]    mem [`fifoDepth];
	logic [`fifoAddrLen-1:0] wrPtr, rdPtr;
	logic [cntLen-1:0]       count;            // occupancy
	logic                    pushOk, popOk;

	assign pushOk = push && !full;
	assign popOk = pop && !empty;

	assign full = (count == maxCnt);
	assign empty = (count == '0);
	assign popData = mem[rdPtr];   // show-ahead so the head latches with the pop

	// storage
	always_ff @(posedge clk)
	begin
		if (pushOk)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1;   // depth is a power of two, wraps itself
			if (popOk)
				rdPtr <= rdPtr + 1'b1;
			case ({pushOk, popOk})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count;       // none or both
			endcase
		end
	end

	// the host port and transmitter must respect the flags
	assert property (@(posedge clk) disable iff (reset) full |-> !push);
	assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

`default_nettype wire

//--- hdl/uartTrans.sv
// uart transmitter
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module uartTrans (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sTick,
	input  logic                 txStart,      // fifo not empty
	input  logic [`dataBits-1:0] din,          // fifo head
	output logic                 txDoneTick,   // pops the fifo
	output logic                 tx,
	output logic                 busy,
	output logic                 frameEnd      // last tick of the stop bit
);

	localparam int sLen = $clog2(`sbTick);
	localparam int nLen = $clog2(`dataBits);
	localparam logic [sLen-1:0] bitLast = sLen'(15);   // 16x oversampling
	localparam logic [sLen-1:0] stopLast = sLen'(`sbTick - 1);
	localparam logic [nLen-1:0] nLast = nLen'(`dataBits - 1);

	uartPkg::txState_e stateReg, stateNext;
	logic [sLen-1:0]      sReg, sNext;     // tick counter within a bit
	logic [nLen-1:0]      nReg, nNext;     // data bit counter
	logic [`dataBits-1:0] bReg, bNext;     // shift register
	logic                 txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			bReg <= '0;
			txReg <= 1'b1;   // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			bReg <= bNext;
			txReg <= txNext;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;   // pop, head byte taken now
					bNext = din;
					txNext = 1'b0;       // start bit on the next clock
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end

			uartPkg::start:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						nNext = '0;
						stateNext = uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartPkg::data:
			begin
				txNext = bReg[0];   // lsb first
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == nLast)
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartPkg::stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == stopLast)
						stateNext = uartPkg::idle;
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign tx = txReg;
	assign busy = (stateReg != uartPkg::idle);
	assign frameEnd = (stateReg == uartPkg::stop) && sTick && (sReg == stopLast);

	// line is a pure register stage
	assert property (@(posedge clk) disable iff (reset) 1'b1 |=> (tx == $past(txNext)));
	// pops only from idle and only with data waiting
	assert property (@(posedge clk) disable iff (reset)
		txDoneTick |-> (stateReg == uartPkg::idle) && txStart);

endmodule

`default_nettype wire

//--- hdl/hostPort.sv
// host command port
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module hostPort (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   req,
	input  uartPkg::hostCmd_t                      cmd,
	output logic                                   ack,
	output uartPkg::hostRsp_t                      rsp,
	output logic [`txChannels-1:0]                 push,
	output logic [`dataBits-1:0]                   pushData,
	input  logic [`txChannels-1:0]                 full,
	input  uartPkg::chanStatus_t [`txChannels-1:0] status
);

	// four-phase slave
	enum logic [1:0] {hsWait, hsDone, hsRelease} hsState;

	logic isSend;    // opcode decode
	logic cmdDone;   // command finishes this cycle
	logic sendOk;

	assign isSend = (cmd.op == uartPkg::opSend);
	// a full fifo holds the command in wait, the only back-pressure
	assign cmdDone = (hsState == hsWait) && req && (!isSend || !full[cmd.chan]);
	assign sendOk = cmdDone && isSend;

	always_comb
	begin
		push = '0;
		push[cmd.chan] = sendOk;   // single cycle, wait is left at once
	end
	assign pushData = cmd.data;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			hsState <= hsWait;
		else
		begin
			case (hsState)
				hsWait:
					if (cmdDone)
						hsState <= hsDone;
				hsDone:
					if (!req)
						hsState <= hsRelease;   // ack drops on this edge
				default:
					hsState <= hsWait;
			endcase
		end
	end

	assign ack = (hsState == hsDone);

	// response held while ack is high
	always_ff @(posedge clk)
	begin
		if (cmdDone)
		begin
			rsp.accepted <= isSend;
			rsp.data <= status[cmd.chan].sentCount;
		end
	end

	assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
		else $error("ack raised with no request pending");

endmodule

`default_nettype wire

//--- hdl/txStatus.sv
// lane status collector
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module txStatus (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [`txChannels-1:0]                 frameEnd,
	input  logic [`txChannels-1:0]                 laneBusy,
	input  logic [`txChannels-1:0]                 fifoEmpty,
	output uartPkg::chanStatus_t [`txChannels-1:0] status
);

	logic [`countLen-1:0] sentCnt [`txChannels];   // completed frames

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `txChannels; i++)
				sentCnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `txChannels; i++)
				if (frameEnd[i])
					sentCnt[i] <= sentCnt[i] + 1'b1;   // wraps at 256
		end
	end

	always_comb
	begin
		for (int i = 0; i < `txChannels; i++)
		begin
			status[i].busy = laneBusy[i] || !fifoEmpty[i];   // sending or queued
			status[i].sentCount = sentCnt[i];
		end
	end

endmodule

`default_nettype wire

//--- hdl/uartTxTop.sv
// four lane uart transmit top
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module uartTxTop (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   req,
	input  uartPkg::hostCmd_t      cmd,
	output logic                   ack,
	output uartPkg::hostRsp_t      rsp,
	output logic [`txChannels-1:0] tx
);

	logic                                   sTick;
	logic [`txChannels-1:0]                 push, full, empty;
	logic [`txChannels-1:0]                 pop, busy, frameEnd;
	logic [`dataBits-1:0]                   pushData;    // shared by all fifos
	uartPkg::chanStatus_t [`txChannels-1:0] status;

	baudGen baud (
		.clk   (clk),
		.reset (reset),
		.sTick (sTick)
	);

	hostPort host (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.cmd      (cmd),
		.ack      (ack),
		.rsp      (rsp),
		.push     (push),
		.pushData (pushData),
		.full     (full),
		.status   (status)
	);

	////////////////////////////////////////////////////////////////////////////
	// lanes

	for (genvar i = 0; i < `txChannels; i++)
	begin : lane
		logic [`dataBits-1:0] headByte;

		txFifo fifo (
			.clk      (clk),
			.reset    (reset),
			.push     (push[i]),
			.pushData (pushData),
			.pop      (pop[i]),
			.popData  (headByte),
			.full     (full[i]),
			.empty    (empty[i])
		);

		uartTrans trans (
			.clk        (clk),
			.reset      (reset),
			.sTick      (sTick),
			.txStart    (!empty[i]),
			.din        (headByte),
			.txDoneTick (pop[i]),
			.tx         (tx[i]),
			.busy       (busy[i]),
			.frameEnd   (frameEnd[i])
		);
	end

	txStatus stat (
		.clk       (clk),
		.reset     (reset),
		.frameEnd  (frameEnd),
		.laneBusy  (busy),
		.fifoEmpty (empty),
		.status    (status)
	);

endmodule

`default_nettype wire

//--- tb/serialMonitor.sv
// serial line monitor
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module serialMonitor (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 line,      // tx line under watch
	output logic                 rxValid,   // one clock per received frame
	output logic [`dataBits-1:0] rxByte,
	output logic                 frameOk    // start bit low and stop bit high
);

	localparam int bitClocks = 16 * `baudDivisor;   // 16 ticks per bit
	localparam int halfBit = bitClocks / 2;
	localparam int stopIdx = `dataBits + 1;

	logic                 lineQ;      // previous line sample
	logic                 active;
	int                   clkCnt;     // position inside the bit
	int                   bitIdx;     // 0 start, then data, then stop
	logic [`dataBits-1:0] shiftReg;
	logic                 startLow;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lineQ <= 1'b1;
			active <= 1'b0;
			clkCnt <= 0;
			bitIdx <= 0;
			shiftReg <= '0;
			startLow <= 1'b0;
			rxValid <= 1'b0;
			rxByte <= '0;
			frameOk <= 1'b0;
		end
		else
		begin
			lineQ <= line;
			rxValid <= 1'b0;
			if (!active)
			begin
				// falling edge opens a frame
				if (lineQ && !line)
				begin
					active <= 1'b1;
					clkCnt <= 1;
					bitIdx <= 0;
				end
			end
			else
			begin
				clkCnt <= (clkCnt == bitClocks - 1) ? 0 : clkCnt + 1;
				if (clkCnt == halfBit)   // mid-bit sample point
				begin
					bitIdx <= bitIdx + 1;
					if (bitIdx == 0)
						startLow <= !line;
					else if (bitIdx < stopIdx)
						shiftReg <= {line, shiftReg[`dataBits-1:1]};   // lsb arrives first
					else
					begin
						rxValid <= 1'b1;   // stop bit reached
						rxByte <= shiftReg;
						frameOk <= startLow && line;
						active <= 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/uartTxTb.sv
// four lane uart transmit testbench
`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module uartTxTb;

	localparam int bitClocks = 16 * `baudDivisor;
	localparam int frameClocks = 10 * bitClocks;      // start, 8 data, stop
	localparam int ackLimit = 3 * frameClocks;        // covers a full fifo stall
	localparam int releaseLimit = 8;
	localparam int drainLimit = 16 * frameClocks;

	logic                   clk;
	logic                   reset;
	logic                   req;
	uartPkg::hostCmd_t      cmd;
	logic                   ack;
	uartPkg::hostRsp_t      rsp;
	logic [`txChannels-1:0] tx;

	logic [`txChannels-1:0] rxValid, frameOk;
	logic [`dataBits-1:0]   rxByte [`txChannels];

	logic [`dataBits-1:0] expQ [`txChannels][$];   // bytes in flight per lane
	int                   sentCnt [`txChannels];    // accepted sends per lane
	integer               seed;
	string                testName;
	int                   lineErrs = 0;
	int                   hostErrs = 0;
	int                   protoErrs = 0;

	uartTxTop uut (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.cmd   (cmd),
		.ack   (ack),
		.rsp   (rsp),
		.tx    (tx)
	);

	for (genvar i = 0; i < `txChannels; i++)
	begin : mon
		serialMonitor sm (
			.clk     (clk),
			.reset   (reset),
			.line    (tx[i]),
			.rxValid (rxValid[i]),
			.rxByte  (rxByte[i]),
			.frameOk (frameOk[i])
		);
	end

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns
	end

	////////////////////////////////////////////////////////////////////////////
	// checkers

	always @(posedge clk)
	begin : checkLines
		logic [`dataBits-1:0] expected;
		for (int i = 0; i < `txChannels; i++)
		begin
			if (rxValid[i])
			begin
				assert (frameOk[i]) else
				begin
					lineErrs++;
					$display("Frame error in %s: lane %0d bad start or stop bit", testName, i);
				end
				assert (expQ[i].size() != 0) else
				begin
					lineErrs++;
					$display("Unexpected byte %02h on lane %0d in %s", rxByte[i], i, testName);
				end
				if (expQ[i].size() != 0)
				begin
					expected = expQ[i].pop_front();   // order per lane
					assert (rxByte[i] == expected) else
					begin
						lineErrs++;
						$display("Mismatch in %s: lane %0d expected %02h, actual %02h",
							testName, i, expected, rxByte[i]);
					end
				end
			end
		end
	end

	// four-phase rules
	assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req) else
	begin
		protoErrs++;
		$display("Handshake error: ack rose while req was low");
	end
	assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req)) else
	begin
		protoErrs++;
		$display("Handshake error: ack fell while req was still high");
	end

	////////////////////////////////////////////////////////////////////////////
	// host driver

	task automatic handshake(input uartPkg::hostOp_e op, input logic [`chanSelLen-1:0] chan,
		input logic [`dataBits-1:0] data, output uartPkg::hostRsp_t r, output int waited);
		uartPkg::hostCmd_t c;
		int releaseWait;
		c.op = op;
		c.chan = chan;
		c.data = data;
		@(posedge clk);
		cmd <= c;
		req <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!ack && waited < ackLimit)   // full fifo stalls here
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
		begin
			hostErrs++;
			$display("Timeout in %s: no ack after %0d cycles", testName, ackLimit);
		end
		r = rsp;
		@(posedge clk);
		req <= 1'b0;
		releaseWait = 0;
		@(negedge clk);
		while (ack && releaseWait < releaseLimit)
		begin
			@(negedge clk);
			releaseWait++;
		end
		if (ack)
		begin
			hostErrs++;
			$display("Timeout in %s: ack stayed high after req was released", testName);
		end
	endtask

	task automatic sendByte(input logic [`chanSelLen-1:0] chan,
		input logic [`dataBits-1:0] data, output int waited);
		uartPkg::hostRsp_t r;
		handshake(uartPkg::opSend, chan, data, r, waited);
		assert (r.accepted) else
		begin
			hostErrs++;
			$display("Mismatch in %s: lane %0d accepted expected 1, actual %b",
				testName, chan, r.accepted);
		end
		if (r.accepted)
		begin
			expQ[chan].push_back(data);
			sentCnt[chan]++;
		end
	endtask

	task automatic readCount(input logic [`chanSelLen-1:0] chan);
		uartPkg::hostRsp_t r;
		int waited;
		handshake(uartPkg::opCount, chan, '0, r, waited);
		assert (!r.accepted) else
		begin
			hostErrs++;
			$display("Mismatch in %s: lane %0d accepted expected 0, actual %b",
				testName, chan, r.accepted);
		end
		// counter wraps at 256
		assert (r.data == `countLen'(sentCnt[chan])) else
		begin
			hostErrs++;
			$display("Mismatch in %s: lane %0d count expected %0d, actual %0d",
				testName, chan, `countLen'(sentCnt[chan]), r.data);
		end
	endtask

	function automatic int queuedBytes();
		int total;
		total = 0;
		for (int i = 0; i < `txChannels; i++)
			total += expQ[i].size();
		return total;
	endfunction

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (queuedBytes() != 0 && cycles < drainLimit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (queuedBytes() != 0)
		begin
			hostErrs++;
			$display("Timeout in %s: %0d bytes never came out on the lines", testName,
				queuedBytes());
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence

	initial
	begin
		int waited;
		int maxWait;
		reset = 1'b1;
		req = 1'b0;
		cmd = '0;
		seed = 32'he9ec_a2d2;
		testName = "reset";
		for (int i = 0; i < `txChannels; i++)
			sentCnt[i] = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// idle lines, no ack before the first req
		repeat (4)
		begin
			@(negedge clk);
			assert (tx == '1) else
			begin
				hostErrs++;
				$display("Mismatch in %s: tx expected %b, actual %b",
					testName, {`txChannels{1'b1}}, tx);
			end
			assert (!ack) else
			begin
				hostErrs++;
				$display("Mismatch in %s: ack expected 0, actual %b", testName, ack);
			end
		end

		testName = "single byte";
		sendByte(0, `dataBits'($random(seed)), waited);
		waitDrain();

		testName = "interleaved lanes";
		for (int round = 0; round < 3; round++)
			for (int lane = 0; lane < `txChannels; lane++)
				sendByte(`chanSelLen'(lane), `dataBits'($random(seed)), waited);
		waitDrain();

		// one popped at once, eight queued, the tenth must stall
		testName = "burst";
		maxWait = 0;
		for (int n = 0; n < 10; n++)
		begin
			sendByte(1, `dataBits'($random(seed)), waited);
			if (waited > maxWait)
				maxWait = waited;
		end
		assert (maxWait > bitClocks) else
		begin
			hostErrs++;
			$display("Burst to a full fifo never stalled ack");
		end
		waitDrain();

		testName = "frame count";
		repeat (bitClocks) @(negedge clk);   // last stop bit and counter update
		for (int lane = 0; lane < `txChannels; lane++)
			readCount(`chanSelLen'(lane));

		$display("errors: serial %0d, host %0d, handshake %0d", lineErrs, hostErrs, protoErrs);
		if (lineErrs + hostErrs + protoErrs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/uartPkg.sv
hdl/baudGen.sv
hdl/txFifo.sv
hdl/uartTrans.sv
hdl/hostPort.sv
hdl/txStatus.sv
hdl/uartTxTop.sv
tb/serialMonitor.sv
tb/uartTxTb.sv

//--- Makefile
TOP = uartTxTb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f files.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module uartTxTop -f files.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
